/* source/pat_pkg.sv */
package pat_pkg;

	// ======================================================================
	// widths
	// ======================================================================
	localparam int DATA_W     = 8;  // datapath width
	localparam int INSTR_W    = 23; // instruction word width
	localparam int REG_ADR_W  = 3;  // register file address
	localparam int NUM_REGS   = 8;
	localparam int NUM_INPUTS = 3;  // input ports selected one-hot by imm3
	localparam int SHAMT_W    = 3;  // shift amount taken from b[2:0]
	localparam int OPC_W      = 4;  // every opcode field is 4 bits

	// ignored field pointer, condition and field-op bits
	localparam int UNUSED_W   = INSTR_W - REG_ADR_W - OPC_W - DATA_W;

	localparam logic [OPC_W-1:0] OPC_PREFIX = 4'b1111; // escape into the next format

	// ======================================================================
	// opcodes
	// ======================================================================
	// i8 space where 9..14 behave as nop
	localparam logic [OPC_W-1:0] OPC_ORI  = 4'd0;
	localparam logic [OPC_W-1:0] OPC_ORR  = 4'd1;
	localparam logic [OPC_W-1:0] OPC_ANDI = 4'd2;
	localparam logic [OPC_W-1:0] OPC_ANDR = 4'd3;
	localparam logic [OPC_W-1:0] OPC_ADDI = 4'd4;
	localparam logic [OPC_W-1:0] OPC_ADDR = 4'd5;
	localparam logic [OPC_W-1:0] OPC_SUBI = 4'd6;
	localparam logic [OPC_W-1:0] OPC_SUBR = 4'd7;
	localparam logic [OPC_W-1:0] OPC_LDI  = 4'd8;

	// i3 space in imm[7:4]
	localparam logic [OPC_W-1:0] OPC_SHLZI = 4'd0;
	localparam logic [OPC_W-1:0] OPC_SHLZR = 4'd1;
	localparam logic [OPC_W-1:0] OPC_SHLOI = 4'd2;
	localparam logic [OPC_W-1:0] OPC_SHLOR = 4'd3;
	localparam logic [OPC_W-1:0] OPC_SHRZI = 4'd4;
	localparam logic [OPC_W-1:0] OPC_SHRZR = 4'd5;
	localparam logic [OPC_W-1:0] OPC_ASRI  = 4'd6;
	localparam logic [OPC_W-1:0] OPC_ASRR  = 4'd7;
	localparam logic [OPC_W-1:0] OPC_IN    = 4'd10; // own code apart from shrzi
	localparam logic [OPC_W-1:0] OPC_OUT   = 4'd11;

	// i0 space in imm[3:0]
	localparam logic [OPC_W-1:0] OPC_NOT = 4'd0;
	localparam logic [OPC_W-1:0] OPC_NOP = 4'd15;

	// both prefixes set and i0 nop code
	localparam logic [INSTR_W-1:0] INSTR_NOP = 23'h000fff;

	// ======================================================================
	// types
	// ======================================================================
	typedef struct packed {
		logic [REG_ADR_W-1:0] rn;     // source and destination register
		logic [UNUSED_W-1:0]  unused; // bits 19:12
		logic [OPC_W-1:0]     opc8;   // i8 opcode or prefix
		logic [DATA_W-1:0]    imm;    // i8 immediate / i3 opcode+imm3 / i0 opcode
	} instr_t;

	typedef enum logic [3:0] {
		ALU_NONE,
		ALU_OR,
		ALU_AND,
		ALU_ADD,
		ALU_SUB,
		ALU_PASS_B, // ldi and in
		ALU_NOT,
		ALU_SHLZ,
		ALU_SHLO,
		ALU_SHRZ,
		ALU_ASR
	} alu_op_e;

	typedef struct packed {
		logic                 valid;
		alu_op_e              op;
		logic                 use_reg_b; // b operand comes from rb
		logic [REG_ADR_W-1:0] rn;
		logic [REG_ADR_W-1:0] rb;
		logic [DATA_W-1:0]    imm_val;   // immediate or sampled input
		logic                 wr_en;
		logic                 out_en;
	} dec_t;

	typedef struct packed {
		logic [REG_ADR_W-1:0] rn;
		logic [DATA_W-1:0]    value;
		logic                 wr_en;
		logic                 out_en;
	} result_t;

endpackage

/* source/pat_alu.sv */
module pat_alu import pat_pkg::*;
(
	input  alu_op_e           i_op,
	input  logic [DATA_W-1:0] i_a,
	input  logic [DATA_W-1:0] i_b,
	output logic [DATA_W-1:0] o_y
);

	logic               is_sub;
	logic [DATA_W-1:0]  b_inv;   // b or ~b for subtract
	logic [DATA_W-1:0]  sum;     // shared add/sub result, wraps mod 256
	logic [SHAMT_W-1:0] shamt;
	logic [DATA_W-1:0]  ones;    // fill mask for shlo

	// ======================================================================
	// add/sub on one adder
	// ======================================================================
	assign is_sub = (i_op == ALU_SUB);
	assign b_inv  = is_sub ? ~i_b : i_b;
	assign sum    = i_a + b_inv + {{(DATA_W-1){1'b0}}, is_sub}; // a + ~b + 1

	// ======================================================================
	// shifter
	// ======================================================================
	assign shamt = i_b[SHAMT_W-1:0];
	assign ones  = ~({DATA_W{1'b1}} << shamt); // low shamt bits set

	always_comb
	begin
		case (i_op)
			ALU_OR:     o_y = i_a | i_b;
			ALU_AND:    o_y = i_a & i_b;
			ALU_ADD,
			ALU_SUB:    o_y = sum;
			ALU_PASS_B: o_y = i_b;             // ldi, in
			ALU_NOT:    o_y = ~i_a;
			ALU_SHLZ:   o_y = i_a << shamt;
			ALU_SHLO:   o_y = (i_a << shamt) | ones;
			ALU_SHRZ:   o_y = i_a >> shamt;
			ALU_ASR:    o_y = DATA_W'($signed(i_a) >>> shamt); // sign fill
			default:    o_y = '0;
		endcase
	end

endmodule

/* source/pat_decode.sv */
module pat_decode import pat_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_instr_valid,
	input  instr_t                       i_instr,
	input  logic [NUM_INPUTS*DATA_W-1:0] i_inputs,
	output dec_t                         o_dec
);

	instr_t            instr;    // instruction after idle substitution
	logic [OPC_W-1:0]  opc3;
	logic [OPC_W-1:0]  opc0;
	logic [2:0]        imm3;
	logic              is_in;    // in selects the input mux for imm_val
	logic [DATA_W-1:0] in_sel;   // one-hot picked input port
	dec_t              dec_nxt;

	// ======================================================================
	// field split
	// ======================================================================
	assign instr = i_instr_valid ? i_instr : instr_t'(INSTR_NOP); // idle cycle is a nop
	assign opc3  = instr.imm[7:4];
	assign opc0  = instr.imm[3:0];
	assign imm3  = instr.imm[2:0];

	// input port pick, non one-hot falls back to port 0
	always_comb
	begin
		case (imm3)
			3'b010:  in_sel = i_inputs[1*DATA_W +: DATA_W];
			3'b100:  in_sel = i_inputs[2*DATA_W +: DATA_W];
			default: in_sel = i_inputs[0 +: DATA_W];
		endcase
	end

	// ======================================================================
	// opcode decode through the prefix chain
	// ======================================================================
	always_comb
	begin
		dec_nxt           = '0;
		dec_nxt.valid     = i_instr_valid;
		dec_nxt.op        = ALU_NONE;
		dec_nxt.rn        = instr.rn;
		dec_nxt.rb        = instr.imm[REG_ADR_W-1:0]; // register forms name rb in the low bits
		is_in             = 1'b0;

		if (instr.opc8 != OPC_PREFIX)
		begin
			// i8 format, odd codes are register forms
			case (instr.opc8)
				OPC_ORI,  OPC_ORR:  dec_nxt.op = ALU_OR;
				OPC_ANDI, OPC_ANDR: dec_nxt.op = ALU_AND;
				OPC_ADDI, OPC_ADDR: dec_nxt.op = ALU_ADD;
				OPC_SUBI, OPC_SUBR: dec_nxt.op = ALU_SUB;
				OPC_LDI:            dec_nxt.op = ALU_PASS_B;
				default:            dec_nxt.op = ALU_NONE;
			endcase
			dec_nxt.use_reg_b = (instr.opc8 < OPC_LDI) && instr.opc8[0];
			dec_nxt.imm_val   = instr.imm;
		end
		else if (opc3 != OPC_PREFIX)
		begin
			// i3 format, shifts in the same odd/even pattern
			case (opc3)
				OPC_SHLZI, OPC_SHLZR: dec_nxt.op = ALU_SHLZ;
				OPC_SHLOI, OPC_SHLOR: dec_nxt.op = ALU_SHLO;
				OPC_SHRZI, OPC_SHRZR: dec_nxt.op = ALU_SHRZ;
				OPC_ASRI,  OPC_ASRR:  dec_nxt.op = ALU_ASR;
				OPC_IN:
				begin
					dec_nxt.op = ALU_PASS_B;
					is_in      = 1'b1;
				end
				OPC_OUT:              dec_nxt.out_en = 1'b1;
				default:              dec_nxt.op = ALU_NONE;
			endcase
			dec_nxt.use_reg_b = (opc3 < OPC_IN) && opc3[0];
			// in samples the port here, at its decode edge
			dec_nxt.imm_val   = is_in ? in_sel : {{(DATA_W-3){1'b0}}, imm3};
		end
		else
		begin
			// i0 format, no operand
			case (opc0)
				OPC_NOT: dec_nxt.op = ALU_NOT;
				OPC_NOP: dec_nxt.op = ALU_NONE;
				default: dec_nxt.op = ALU_NONE;
			endcase
		end

		// out and every nop code leave op at none
		dec_nxt.wr_en = (dec_nxt.op != ALU_NONE);
	end

	// ======================================================================
	// pipeline register
	// ======================================================================
	always_ff @(posedge clk)
	begin
		o_dec <= dec_nxt;
		if (reset)
			o_dec.valid <= 1'b0; // execute gates writes with valid
	end

endmodule

/* source/pat_execute.sv */
module pat_execute import pat_pkg::*;
(
	input  dec_t                  i_dec,
	output logic [REG_ADR_W-1:0]  o_rd_addr_a,
	output logic [REG_ADR_W-1:0]  o_rd_addr_b,
	input  logic [DATA_W-1:0]     i_rd_data_a,
	input  logic [DATA_W-1:0]     i_rd_data_b,
	output result_t               o_result
);

	logic [DATA_W-1:0] op_b;  // selected second operand
	logic [DATA_W-1:0] alu_y;

	// ======================================================================
	// operand fetch
	// ======================================================================
	assign o_rd_addr_a = i_dec.rn; // a is always rn
	assign o_rd_addr_b = i_dec.rb;

	// one alu, the mux sits in front of b
	assign op_b = i_dec.use_reg_b ? i_rd_data_b : i_dec.imm_val;

	pat_alu u_alu
	(
		.i_op (i_dec.op),
		.i_a  (i_rd_data_a),
		.i_b  (op_b),
		.o_y  (alu_y)
	);

	// ======================================================================
	// result
	// ======================================================================
	always_comb
	begin
		o_result.rn     = i_dec.rn;
		o_result.value  = i_dec.out_en ? i_rd_data_a : alu_y; // out sends rn as is
		o_result.wr_en  = i_dec.valid & i_dec.wr_en;
		o_result.out_en = i_dec.valid & i_dec.out_en;
	end

endmodule

/* source/pat_commit.sv */
module pat_commit import pat_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [REG_ADR_W-1:0]  i_rd_addr_a,
	input  logic [REG_ADR_W-1:0]  i_rd_addr_b,
	output logic [DATA_W-1:0]     o_rd_data_a,
	output logic [DATA_W-1:0]     o_rd_data_b,
	input  result_t               i_result,
	output logic [DATA_W-1:0]     o_out,
	output logic                  o_out_valid
);

	logic [DATA_W-1:0] regs [NUM_REGS]; // register file

	// ======================================================================
	// read ports, combinational
	// ======================================================================
	assign o_rd_data_a = regs[i_rd_addr_a];
	assign o_rd_data_b = regs[i_rd_addr_b];

	// ======================================================================
	// write port and output port
	// ======================================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_REGS; i++)
				regs[i] <= '0;
			o_out       <= '0;
			o_out_valid <= 1'b0;
		end
		else
		begin
			if (i_result.wr_en)
				regs[i_result.rn] <= i_result.value;
			o_out_valid <= i_result.out_en; // one cycle pulse per out
			if (i_result.out_en)
				o_out <= i_result.value;   // held until the next out
		end
	end

endmodule

/* source/pat_core.sv */
module pat_core import pat_pkg::*;
(
	input  logic                         clk,
	input  logic                         reset,
	input  logic                         i_instr_valid,
	input  instr_t                       i_instr,
	input  logic [NUM_INPUTS*DATA_W-1:0] i_inputs,
	output logic [DATA_W-1:0]            o_out,
	output logic                         o_out_valid
);

	dec_t                 dec;       // decode to execute
	result_t              result;    // execute to commit
	logic [REG_ADR_W-1:0] rd_addr_a;
	logic [REG_ADR_W-1:0] rd_addr_b;
	logic [DATA_W-1:0]    rd_data_a;
	logic [DATA_W-1:0]    rd_data_b;

	// stage 1, decode and operand select
	pat_decode u_decode
	(
		.clk           (clk),
		.reset         (reset),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_inputs      (i_inputs),
		.o_dec         (dec)
	);

	// stage 2, alu
	pat_execute u_execute
	(
		.i_dec       (dec),
		.o_rd_addr_a (rd_addr_a),
		.o_rd_addr_b (rd_addr_b),
		.i_rd_data_a (rd_data_a),
		.i_rd_data_b (rd_data_b),
		.o_result    (result)
	);

	// register file and output port
	pat_commit u_commit
	(
		.clk         (clk),
		.reset       (reset),
		.i_rd_addr_a (rd_addr_a),
		.i_rd_addr_b (rd_addr_b),
		.o_rd_data_a (rd_data_a),
		.o_rd_data_b (rd_data_b),
		.i_result    (result),
		.o_out       (o_out),
		.o_out_valid (o_out_valid)
	);

endmodule

/* testbench/tb_clock.sv */
module tb_clock
(
	output logic o_clk
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4; // 8 ns period

	initial
	begin
		o_clk = 1'b0;
		forever
			#HALF_PERIOD o_clk = ~o_clk;
	end

endmodule

/* testbench/tb_pat_model.svh */
`ifndef TB_PAT_MODEL_SVH
`define TB_PAT_MODEL_SVH

// ======================================================================
// random source and model state
// ======================================================================
logic [31:0]       lcg_state = 32'd73;    // seed
logic [DATA_W-1:0] model_regs [NUM_REGS]; // mirror of the register file
logic [DATA_W-1:0] exp_q [$];             // expected o_out values, issue order

function automatic logic [31:0] lcg_next();
	lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
	return lcg_state;
endfunction

// upper bits only, the low ones repeat with a short period
function automatic int rand_below(input int n);
	return int'(lcg_next() >> 16) % n;
endfunction

function automatic logic [DATA_W-1:0] rand_byte();
	return DATA_W'(lcg_next() >> 16);
endfunction

// ======================================================================
// instruction encoders
// ======================================================================
function automatic instr_t enc_i8(input logic [3:0] opc, input logic [2:0] rn,
	input logic [DATA_W-1:0] imm);
	instr_t ins;
	ins      = '0;
	ins.rn   = rn;
	ins.opc8 = opc;
	ins.imm  = imm;
	return ins;
endfunction

function automatic instr_t enc_i3(input logic [3:0] opc, input logic [2:0] rn,
	input logic [2:0] lo3);
	return enc_i8(OPC_PREFIX, rn, {opc, 1'b0, lo3}); // imm[3] is a don't care
endfunction

function automatic instr_t enc_i0(input logic [3:0] opc, input logic [2:0] rn);
	return enc_i8(OPC_PREFIX, rn, {OPC_PREFIX, opc});
endfunction

// ======================================================================
// reference model, one instruction at issue
// ======================================================================
function automatic void model_exec(input instr_t ins,
	input logic [NUM_INPUTS*DATA_W-1:0] ports);
	logic [DATA_W-1:0] a;
	logic [DATA_W-1:0] src;
	logic [DATA_W-1:0] res;
	logic [3:0]        opc3;
	logic [2:0]        lo3;
	int                amt;
	logic              write;
	a     = model_regs[ins.rn];
	opc3  = ins.imm[7:4];
	lo3   = ins.imm[2:0];
	res   = a;
	write = 1'b1;
	if (ins.opc8 != OPC_PREFIX)
	begin
		src = ins.imm;
		if (ins.opc8 inside {OPC_ORR, OPC_ANDR, OPC_ADDR, OPC_SUBR})
			src = model_regs[lo3]; // register form
		case (ins.opc8)
			OPC_ORI, OPC_ORR:   res = a | src;
			OPC_ANDI, OPC_ANDR: res = a & src;
			OPC_ADDI, OPC_ADDR: res = a + src; // wraps at 8 bits
			OPC_SUBI, OPC_SUBR: res = a - src;
			OPC_LDI:            res = ins.imm;
			default:            write = 1'b0;
		endcase
	end
	else if (opc3 != OPC_PREFIX)
	begin
		src = DATA_W'(lo3);
		if (opc3 inside {OPC_SHLZR, OPC_SHLOR, OPC_SHRZR, OPC_ASRR})
			src = model_regs[lo3];
		amt = int'(src[2:0]); // only the low 3 bits count
		case (opc3)
			OPC_SHLZI, OPC_SHLZR:
				for (int i = 0; i < amt; i++)
					res = {res[DATA_W-2:0], 1'b0};
			OPC_SHLOI, OPC_SHLOR:
				for (int i = 0; i < amt; i++)
					res = {res[DATA_W-2:0], 1'b1};
			OPC_SHRZI, OPC_SHRZR:
				for (int i = 0; i < amt; i++)
					res = {1'b0, res[DATA_W-1:1]};
			OPC_ASRI, OPC_ASRR:
				for (int i = 0; i < amt; i++)
					res = {res[DATA_W-1], res[DATA_W-1:1]};
			OPC_IN:
				case (lo3)
					3'b010:  res = ports[DATA_W +: DATA_W];
					3'b100:  res = ports[2*DATA_W +: DATA_W];
					default: res = ports[0 +: DATA_W]; // 001 and non one-hot
				endcase
			OPC_OUT:
			begin
				exp_q.push_back(a);
				write = 1'b0;
			end
			default: write = 1'b0;
		endcase
	end
	else if (ins.imm[3:0] == OPC_NOT)
		res = ~a;
	else
		write = 1'b0; // every other i0 code
	if (write)
		model_regs[ins.rn] = res;
endfunction

`endif

/* testbench/tb_pat_core.sv */
module tb_pat_core import pat_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int OUT_TIMEOUT   = 20; // cycles an owed out may take
	localparam int DRAIN_TIMEOUT = 50;
	localparam int RESET_TIMEOUT = 10;
	localparam int NUM_RANDOM    = 300;

	logic                         clk;
	logic                         reset;
	logic                         i_instr_valid;
	instr_t                       i_instr;
	logic [NUM_INPUTS*DATA_W-1:0] i_inputs;
	logic [DATA_W-1:0]            o_out;
	logic                         o_out_valid;

	int   value_errs   = 0;
	int   extra_errs   = 0; // pulses with nothing owed
	int   timeout_errs = 0;
	int   missing_errs = 0;
	logic reset_done   = 1'b0;

	`include "tb_pat_model.svh"

	tb_clock u_clock
	(
		.o_clk (clk)
	);

	pat_core uut
	(
		.clk           (clk),
		.reset         (reset),
		.i_instr_valid (i_instr_valid),
		.i_instr       (i_instr),
		.i_inputs      (i_inputs),
		.o_out         (o_out),
		.o_out_valid   (o_out_valid)
	);

	// ======================================================================
	// helpers
	// ======================================================================
	task automatic check_value(input logic [DATA_W-1:0] actual,
		input logic [DATA_W-1:0] expected, input string what);
		if (actual !== expected)
		begin
			value_errs++;
			$display("[ERROR] t=%0.1f ns: %s, got %02h expected %02h",
				$realtime, what, actual, expected);
		end
	endtask

	// drive on the falling edge and run the model at issue
	task automatic issue(input instr_t ins);
		logic [NUM_INPUTS*DATA_W-1:0] ports;
		ports = {rand_byte(), rand_byte(), rand_byte()};
		@(negedge clk);
		i_instr_valid = 1'b1;
		i_instr       = ins;
		i_inputs      = ports;
		model_exec(ins, ports);
	endtask

	task automatic idle_cycle();
		@(negedge clk);
		i_instr_valid = 1'b0;
		i_instr       = enc_i8(4'(rand_below(9)), 3'(rand_below(NUM_REGS)), rand_byte());
		i_inputs      = {rand_byte(), rand_byte(), rand_byte()};
	endtask

	task automatic end_run();
		$display("summary: %0d value mismatches, %0d unexpected pulses, %0d timeouts, %0d missing",
			value_errs, extra_errs, timeout_errs, missing_errs);
		if (value_errs + extra_errs + timeout_errs + missing_errs == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	endtask

	// ======================================================================
	// compare process sampling outputs mid cycle
	// ======================================================================
	initial
	begin
		int                waited;
		logic [DATA_W-1:0] held_out;
		logic              timed_out;
		held_out  = '0;
		timed_out = 1'b0;
		waited    = 0;
		while (!reset_done && waited < RESET_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		while (!timed_out)
		begin
			@(negedge clk);
			waited = 0;
			while (!o_out_valid && !timed_out)
			begin
				check_value(o_out, held_out, "o_out moved without an OUT"); // must hold
				if (exp_q.size() != 0)
					waited++; // only count while an out is owed
				if (waited > OUT_TIMEOUT)
					timed_out = 1'b1;
				else
					@(negedge clk);
			end
			if (!timed_out)
			begin
				if (exp_q.size() == 0)
				begin
					extra_errs++;
					$display("unexpected output: o_out_valid rose with no OUT pending");
				end
				else
					check_value(o_out, exp_q.pop_front(), "OUT value");
				held_out = o_out;
			end
		end
		timeout_errs++;
		$display("timeout: no o_out_valid within %0d cycles of an OUT", OUT_TIMEOUT);
		end_run();
	end

	// ======================================================================
	// stimulus
	// ======================================================================
	initial
	begin
		logic [2:0]        rn;
		logic [2:0]        rb;
		logic [DATA_W-1:0] val;
		instr_t            ins;
		int                sel;
		int                waited;
		reset         = 1'b1;
		i_instr_valid = 1'b0;
		i_instr       = instr_t'(INSTR_NOP);
		i_inputs      = '0;
		foreach (model_regs[i])
			model_regs[i] = '0;
		repeat (2) @(posedge clk); // two rising edges in reset
		@(negedge clk);
		reset      = 1'b0;
		reset_done = 1'b1;

		// quiet output and all registers zero after reset
		repeat (3) idle_cycle();
		for (int r = 0; r < NUM_REGS; r++)
			issue(enc_i3(OPC_OUT, 3'(r), 3'd0));

		// ldi then out of the same register right behind it
		for (int r = 0; r < NUM_REGS; r++)
		begin
			issue(enc_i8(OPC_LDI, 3'(r), rand_byte()));
			issue(enc_i3(OPC_OUT, 3'(r), 3'd0));
		end

		// or, and, add, sub in immediate and register form
		for (int n = 0; n < 64; n++)
		begin
			rn = 3'(rand_below(NUM_REGS));
			if (n % 4 == 0)
				issue(enc_i8(OPC_LDI, rn, rand_byte())); // keep values from settling
			issue(enc_i8(4'(n % 8), rn, rand_byte()));
			issue(enc_i3(OPC_OUT, rn, 3'd0));
		end

		// every shift kind and amount by immediate then by register
		for (int k = 0; k < 4; k++)
			for (int s = 0; s < 8; s++)
			begin
				rn       = 3'(rand_below(NUM_REGS));
				rb       = rn ^ 3'b101;
				val      = rand_byte();
				val[7]   = s[0];  // both signs for asr
				issue(enc_i8(OPC_LDI, rn, val));
				issue(enc_i3(4'(2 * k), rn, 3'(s)));
				issue(enc_i3(OPC_OUT, rn, 3'd0));
				val      = rand_byte();
				val[2:0] = 3'(s); // upper bits are noise
				issue(enc_i8(OPC_LDI, rb, val));
				issue(enc_i3(4'(2 * k + 1), rn, rb));
				issue(enc_i3(OPC_OUT, rn, 3'd0));
			end

		// in with all 8 select codes and not on every register
		for (int c = 0; c < 8; c++)
		begin
			rn = 3'(rand_below(NUM_REGS));
			issue(enc_i3(OPC_IN, rn, 3'(c)));
			issue(enc_i3(OPC_OUT, rn, 3'd0));
		end
		for (int r = 0; r < NUM_REGS; r++)
		begin
			issue(enc_i0(OPC_NOT, 3'(r)));
			issue(enc_i3(OPC_OUT, 3'(r), 3'd0));
		end

		// spare codes in all three formats must change nothing
		for (int c = 9; c < 15; c++)
			issue(enc_i8(4'(c), 3'(c), rand_byte()));
		for (int c = 8; c < 15; c++)
			if (c != 10 && c != 11)
				issue(enc_i3(4'(c), 3'(c), 3'(c)));
		for (int c = 1; c < 16; c++)
			issue(enc_i0(4'(c), 3'(c)));
		for (int r = 0; r < NUM_REGS; r++)
			issue(enc_i3(OPC_OUT, 3'(r), 3'd0));

		// random program with idle gaps and a lot of outs
		for (int n = 0; n < NUM_RANDOM; n++)
		begin
			if (rand_below(8) == 0)
				idle_cycle();
			rn  = 3'(rand_below(NUM_REGS));
			sel = rand_below(16);
			if (sel < 4)
				ins = enc_i3(OPC_OUT, rn, 3'd0);
			else if (sel < 10)
				ins = enc_i8(4'(rand_below(15)), rn, rand_byte());
			else if (sel < 14)
				ins = enc_i3(4'(rand_below(15)), rn, 3'(rand_below(8)));
			else if (sel < 15)
				ins = enc_i0(4'(rand_below(16)), rn);
			else
				ins = instr_t'(INSTR_NOP);
			ins.unused = rand_byte(); // ignored bits
			issue(ins);
		end

		// drain the owed outs
		waited = 0;
		while (exp_q.size() != 0 && waited < DRAIN_TIMEOUT)
		begin
			idle_cycle();
			waited++;
		end
		repeat (4) idle_cycle(); // room for a stray pulse
		if (exp_q.size() != 0)
		begin
			missing_errs = exp_q.size();
			$display("missing outputs: %0d OUT results never appeared", missing_errs);
		end
		end_run();
	end

endmodule

/* files.f */
+incdir+testbench
source/pat_pkg.sv
source/pat_alu.sv
source/pat_decode.sv
source/pat_execute.sv
source/pat_commit.sv
source/pat_core.sv
testbench/tb_clock.sv
testbench/tb_pat_core.sv

/* Makefile */
SIM      = verilator
TOP      = tb_pat_core
FILELIST = files.f
FLAGS    = --binary --timing --timescale 1ns/100ps --top-module $(TOP)
OBJ_DIR  = obj_dir
LOG      = sim.log
PASS_MSG = NO ERRORS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(SIM), run $(TOP), search $(LOG) for the pass line"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "test passed"; \
	else \
		echo "test failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
